/* sources.f */
+incdir+source
source/video_pkg.sv
source/game_pkg.sv
source/ball_rom.sv
source/ball_renderer.sv
source/obstacle_motion.sv
source/maze_walls.sv
source/player_motion.sv
source/pixel_mux.sv
source/maze_pixel_gen.sv
test/tb_maze_pixel_gen.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_maze_pixel_gen
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || [ $$status -ne 0 ]; then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_maze_pixel_gen.sv */
`default_nettype none

`include "maze_defs.svh"

module tb_maze_pixel_gen;

    timeunit 1ns;
    timeprecision 100ps;

    import video_pkg::*;
    import game_pkg::*;

    localparam int          HALF_PERIOD = 4;
    localparam logic [31:0] SEED        = 32'h24e7679a;

    localparam int BALL_SZ     = int'(`BALL_SIZE);
    localparam int PLAYER_SZ   = int'(`PLAYER_SIZE);
    localparam int BALL_STP    = int'(`BALL_STEP);
    localparam int PLAYER_STP  = int'(`PLAYER_STEP);
    localparam int H_LO        = int'(`H_MIN);
    localparam int H_HI        = int'(`H_MAX);
    localparam int V_LO        = int'(`V_MIN);
    localparam int V_HI        = int'(`V_MAX);
    localparam int ROW_TOP     = int'(`COR_LOWER_TOP);    // start corridor edges
    localparam int ROW_FLOOR   = int'(`COR_LOWER_FLOOR);
    localparam int ROW_END     = int'(`COR_MID);
    localparam int RIGHT_LIMIT = int'(`COR_LEFT);
    localparam int LEFT_REACH  = int'(`COR_SHAFT_END);
    localparam int START_PX    = int'(`PLAYER_START_X);
    localparam int START_PY    = int'(`PLAYER_START_Y);
    localparam int LANES [NUM_OBSTACLES] = '{int'(`LANE_X0), int'(`LANE_X1), int'(`LANE_X2),
                                             int'(`LANE_X3), int'(`LANE_Y4), int'(`LANE_Y5)};

    // round sprite with bit 0 as the left column
    localparam logic [7:0] BALL_ROWS [8] = '{8'h3C, 8'h7E, 8'hFF, 8'hFF,
                                             8'hFF, 8'hFF, 8'h7E, 8'h3C};

    localparam int RAND_PROBES  = 48;
    localparam int BOUNCE_TICKS = 150;
    localparam int UP_TICKS     = 45;
    localparam int DOWN_TICKS   = 56;
    localparam int LEFT_TICKS   = 20;
    localparam int CHASE_TICKS  = 700;
    localparam int PLANNED_CYCLES = 4 + RAND_PROBES + NUM_OBSTACLES + 1
        + NUM_OBSTACLES * 64 + PLAYER_SZ * PLAYER_SZ
        + BOUNCE_TICKS * (1 + 2 * NUM_OBSTACLES)
        + (UP_TICKS + DOWN_TICKS + LEFT_TICKS + 2) * 5 + 8
        + CHASE_TICKS * 6 + 8;
    localparam int WATCHDOG_NS = (2 * PLANNED_CYCLES + 200) * 2 * HALF_PERIOD;

    logic   clk;
    logic   reset;
    logic   up;
    logic   down;
    logic   left;
    logic   right;
    logic   video_on;
    coord_t x;
    coord_t y;
    rgb_t   rgb;

    // reference state
    int   m_pos [NUM_OBSTACLES];
    dir_t m_dir_a;      // obstacles 0 and 2
    dir_t m_dir_b;      // obstacles 1 and 3
    dir_t m_dir_4;
    dir_t m_dir_5;
    int   m_px;
    int   m_py;

    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;
    int          t_checks;
    int          t_errors;
    logic        compare_en;
    rgb_t        want;

    maze_pixel_gen dut (
        .clk, .reset, .up, .down, .left, .right, .video_on, .x, .y, .rgb
    );

    always #(HALF_PERIOD) clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic int take_bits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic int box_left(int i);
        return (i < 4) ? LANES[i] : m_pos[i];
    endfunction

    function automatic int box_top(int i);
        return (i < 4) ? m_pos[i] : LANES[i];
    endfunction

    function automatic logic on_ball(int i, int px, int py);
        int dx;
        int dy;
        dx = px - box_left(i);
        dy = py - box_top(i);
        if (dx < 0 || dx >= BALL_SZ || dy < 0 || dy >= BALL_SZ)
            return 1'b0;
        return BALL_ROWS[dy[2:0]][dx[2:0]];
    endfunction

    function automatic logic on_player(int px, int py);
        return px >= m_px && px < m_px + PLAYER_SZ && py >= m_py && py < m_py + PLAYER_SZ;
    endfunction

    // colour priority is blanking, then obstacle, player and background
    function automatic rgb_t expected_rgb(coord_t px, coord_t py, logic von);
        logic ball;
        ball = 1'b0;
        for (int i = 0; i < NUM_OBSTACLES; i++)
            ball |= on_ball(i, int'(px), int'(py));
        if (!von)
            return `BLACK_RGB;
        else if (ball)
            return `BALL_RGB;
        else if (on_player(int'(px), int'(py)))
            return `PLAYER_RGB;
        else
            return `BACKGROUND_RGB;
    endfunction

    function automatic logic any_hit();
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_OBSTACLES; i++)
            hit |= box_left(i) < m_px + PLAYER_SZ && m_px < box_left(i) + BALL_SZ &&
                   box_top(i) < m_py + PLAYER_SZ && m_py < box_top(i) + BALL_SZ;
        return hit;
    endfunction

    // a pixel lit by an obstacle inside the player box
    function automatic logic find_overlap(output int fx, output int fy);
        logic found;
        found = 1'b0;
        fx = 0;
        fy = 0;
        for (int i = 0; i < NUM_OBSTACLES; i++)
            for (int r = 0; r < BALL_SZ; r++)
                for (int c = 0; c < BALL_SZ; c++)
                    if (!found && on_ball(i, box_left(i) + c, box_top(i) + r) &&
                        on_player(box_left(i) + c, box_top(i) + r)) begin
                        found = 1'b1;
                        fx = box_left(i) + c;
                        fy = box_top(i) + r;
                    end
        return found;
    endfunction

    function automatic logic has_room(int p, dir_t d, int lo, int hi);
        return (d == DIR_HIGH) ? p < hi : p > lo;
    endfunction

    function automatic int moved(int p, dir_t d);
        return (d == DIR_HIGH) ? p + BALL_STP : p - BALL_STP;
    endfunction

    function automatic dir_t flipped(dir_t d);
        return (d == DIR_HIGH) ? DIR_LOW : DIR_HIGH;
    endfunction

    task automatic reset_model();
        m_pos[0] = int'(`START_Y0);
        m_pos[1] = int'(`START_Y1);
        m_pos[2] = int'(`START_Y2);
        m_pos[3] = int'(`START_Y3);
        m_pos[4] = int'(`START_X4);
        m_pos[5] = int'(`START_X5);
        m_dir_a = DIR_LOW;
        m_dir_b = DIR_HIGH;
        m_dir_4 = DIR_LOW;
        m_dir_5 = DIR_HIGH;
        m_px = START_PX;
        m_py = START_PY;
    endtask

    // one frame of the game rules computed from the old state
    task automatic advance_model(logic u, logic d, logic l, logic r);
        logic hit;
        logic go_a;
        logic go_b;
        logic rows_ok;
        int   nx;
        int   ny;
        hit  = any_hit();
        go_a = has_room(m_pos[0], m_dir_a, V_LO, V_HI) && has_room(m_pos[2], m_dir_a, V_LO, V_HI);
        go_b = has_room(m_pos[1], m_dir_b, V_LO, V_HI) && has_room(m_pos[3], m_dir_b, V_LO, V_HI);
        if (go_a) begin
            m_pos[0] = moved(m_pos[0], m_dir_a);
            m_pos[2] = moved(m_pos[2], m_dir_a);
        end else begin
            m_dir_a = flipped(m_dir_a);
        end
        if (go_b) begin
            m_pos[1] = moved(m_pos[1], m_dir_b);
            m_pos[3] = moved(m_pos[3], m_dir_b);
        end else begin
            m_dir_b = flipped(m_dir_b);
        end
        if (has_room(m_pos[4], m_dir_4, H_LO, H_HI)) m_pos[4] = moved(m_pos[4], m_dir_4);
        else m_dir_4 = flipped(m_dir_4);
        if (has_room(m_pos[5], m_dir_5, H_LO, H_HI)) m_pos[5] = moved(m_pos[5], m_dir_5);
        else m_dir_5 = flipped(m_dir_5);
        rows_ok = m_py >= ROW_TOP && m_py < ROW_END;
        nx = m_px;
        ny = m_py;
        if (hit) begin
            nx = START_PX;
            ny = START_PY;
        end else begin
            if (u && m_py > ROW_TOP) ny = m_py - PLAYER_STP;
            if (d && m_py < ROW_FLOOR) ny = m_py + PLAYER_STP;
            if (l && rows_ok && m_px > 0 && m_px <= LEFT_REACH) nx = m_px - PLAYER_STP;
            if (r && rows_ok && m_px <= RIGHT_LIMIT) nx = m_px + PLAYER_STP;
        end
        m_px = nx;
        m_py = ny;
    endtask

    task automatic show_pixel(int px, int py, logic von);
        x        <= coord_t'(px);
        y        <= coord_t'(py);
        video_on <= von;
        @(posedge clk);
    endtask

    // one cycle on the retrace pixel and the model follows at the updating edge
    task automatic tick(logic u, logic d, logic l, logic r);
        x        <= `TICK_X;
        y        <= `TICK_Y;
        video_on <= 1'b0;
        up       <= u;
        down     <= d;
        left     <= l;
        right    <= r;
        @(posedge clk);
        advance_model(u, d, l, r);
    endtask

    task automatic probe_player();
        show_pixel(m_px, m_py, 1'b1);
        show_pixel(m_px + PLAYER_SZ - 1, m_py + PLAYER_SZ - 1, 1'b1);
        show_pixel(m_px - 1, m_py, 1'b1);
        show_pixel(m_px, m_py - 1, 1'b1);
    endtask

    task automatic check_pixel(int px, int py, rgb_t exp_rgb, string what);
        x        <= coord_t'(px);
        y        <= coord_t'(py);
        video_on <= 1'b1;
        @(negedge clk);
        n_checks++;
        assert (rgb === exp_rgb) else begin
            n_errors++;
            $display("** Error @ %0t ns: %s, rgb %h at (%0d,%0d), expected %h",
                     $time, what, rgb, px, py, exp_rgb);
        end
        @(posedge clk);
    endtask

    task automatic end_test(string name);
        $display("%s finished: %0d checks, %0d errors", name,
                 n_checks - t_checks, n_errors - t_errors);
        t_checks = n_checks;
        t_errors = n_errors;
    endtask

    always @(negedge clk) begin
        if (compare_en) begin
            want = expected_rgb(x, y, video_on);
            n_checks++;
            assert (rgb === want) else begin
                n_errors++;
                $display("** Error @ %0t ns: rgb %h at (%0d,%0d) video_on %0b, expected %h",
                         $time, rgb, x, y, video_on, want);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int   rx;
        int   ry;
        int   fx;
        int   fy;
        logic hit_seen;
        clk        = 1'b0;
        reset     <= 1'b1;
        up        <= 1'b0;
        down      <= 1'b0;
        left      <= 1'b0;
        right     <= 1'b0;
        video_on  <= 1'b0;
        x         <= '0;
        y         <= '0;
        lfsr       = SEED;
        n_checks   = 0;
        n_errors   = 0;
        t_checks   = 0;
        t_errors   = 0;
        compare_en = 1'b0;
        reset_model();
        repeat (4) @(posedge clk);
        reset     <= 1'b0;
        compare_en = 1'b1;

        for (int i = 0; i < RAND_PROBES; i++) begin
            rx = take_bits(10) % 640;
            ry = take_bits(9) % 480;
            show_pixel(rx, ry, 1'b0);
        end
        for (int i = 0; i < NUM_OBSTACLES; i++)
            show_pixel(box_left(i) + 3, box_top(i) + 3, 1'b0);
        show_pixel(m_px + 5, m_py + 5, 1'b0);
        end_test("video off");

        for (int i = 0; i < NUM_OBSTACLES; i++)
            for (int r = 0; r < BALL_SZ; r++)
                for (int c = 0; c < BALL_SZ; c++)
                    show_pixel(box_left(i) + c, box_top(i) + r, 1'b1);
        for (int r = 0; r < PLAYER_SZ; r++)
            for (int c = 0; c < PLAYER_SZ; c++)
                show_pixel(m_px + c, m_py + r, 1'b1);
        end_test("start picture");

        // centre plus a random pixel within two of each box
        for (int t = 0; t < BOUNCE_TICKS; t++) begin
            tick(1'b0, 1'b0, 1'b0, 1'b0);
            for (int i = 0; i < NUM_OBSTACLES; i++) begin
                show_pixel(box_left(i) + 3, box_top(i) + 4, 1'b1);
                rx = box_left(i) - 2 + take_bits(4) % 12;
                ry = box_top(i) - 2 + take_bits(4) % 12;
                show_pixel(rx, ry, 1'b1);
            end
        end
        end_test("obstacle bounce");

        for (int t = 0; t < UP_TICKS; t++) begin
            tick(1'b1, 1'b0, 1'b0, 1'b0);
            probe_player();
        end
        check_pixel(START_PX, ROW_TOP, `PLAYER_RGB, "player top edge not at y = 320");
        check_pixel(START_PX, ROW_TOP - 1, `BACKGROUND_RGB, "player moved above y = 320");
        for (int t = 0; t < DOWN_TICKS; t++) begin
            tick(1'b0, 1'b1, 1'b0, 1'b0);
            probe_player();
        end
        check_pixel(START_PX, ROW_FLOOR + PLAYER_SZ - 1, `PLAYER_RGB, "player not at y = 372");
        check_pixel(START_PX, ROW_FLOOR + PLAYER_SZ, `BACKGROUND_RGB, "player moved below 372");
        for (int t = 0; t < LEFT_TICKS; t++) begin
            tick(1'b0, 1'b0, 1'b1, 1'b0);
            probe_player();
        end
        check_pixel(0, ROW_FLOOR, `PLAYER_RGB, "player left edge not at x = 0");
        check_pixel(PLAYER_SZ, ROW_FLOOR, `BACKGROUND_RGB, "player wrapped past x = 0");
        // the start corridor still runs up and down at the screen edge
        tick(1'b1, 1'b0, 1'b0, 1'b0);
        probe_player();
        check_pixel(0, ROW_FLOOR - 1, `PLAYER_RGB, "player did not move up at x = 0");
        tick(1'b0, 1'b1, 1'b0, 1'b0);
        probe_player();
        check_pixel(0, ROW_FLOOR + PLAYER_SZ - 1, `PLAYER_RGB, "player stuck going down at x = 0");
        end_test("player corridor");

        // steer toward x = 160 until a lit obstacle pixel sits on the player
        hit_seen = 1'b0;
        for (int t = 0; t < CHASE_TICKS && !hit_seen; t++) begin
            tick(1'b0, 1'b0, 1'b0, m_px < RIGHT_LIMIT);
            probe_player();
            if (any_hit() && find_overlap(fx, fy)) begin
                check_pixel(fx, fy, `BALL_RGB, "player drawn over obstacle");
                hit_seen = 1'b1;
            end
        end
        n_checks++;
        assert (hit_seen) else begin
            n_errors++;
            $display("the player never met an obstacle within %0d frames", CHASE_TICKS);
        end
        if (hit_seen) begin
            tick(1'b0, 1'b0, 1'b0, 1'b0);
            check_pixel(START_PX, START_PY, `PLAYER_RGB, "player not back at start");
            probe_player();
        end
        end_test("collision and priority");

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* source/maze_pixel_gen.sv */
`default_nettype none

`include "maze_defs.svh"

module maze_pixel_gen (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              up,
    input  wire logic              down,
    input  wire logic              left,
    input  wire logic              right,
    input  wire logic              video_on,
    input  wire video_pkg::coord_t x,
    input  wire video_pkg::coord_t y,
    output video_pkg::rgb_t        rgb
);

    import video_pkg::*;
    import game_pkg::*;

    logic                       frame_tick;
    coord_t [NUM_OBSTACLES-1:0] obstacle_pos;
    logic   [NUM_OBSTACLES-1:0] ball_on;
    coord_t                     player_x;
    coord_t                     player_y;
    logic                       can_up;
    logic                       can_down;
    logic                       can_left;
    logic                       can_right;

    obstacle_motion u_obstacles (
        .clk, .reset, .x, .y, .frame_tick, .obstacle_pos
    );

    // four vertical lanes, then two horizontal
    ball_renderer #(.AXIS(LANE_V), .LANE(`LANE_X0)) u_ball0 (
        .x, .y, .pos(obstacle_pos[0]), .ball_on(ball_on[0]));
    ball_renderer #(.AXIS(LANE_V), .LANE(`LANE_X1)) u_ball1 (
        .x, .y, .pos(obstacle_pos[1]), .ball_on(ball_on[1]));
    ball_renderer #(.AXIS(LANE_V), .LANE(`LANE_X2)) u_ball2 (
        .x, .y, .pos(obstacle_pos[2]), .ball_on(ball_on[2]));
    ball_renderer #(.AXIS(LANE_V), .LANE(`LANE_X3)) u_ball3 (
        .x, .y, .pos(obstacle_pos[3]), .ball_on(ball_on[3]));
    ball_renderer #(.AXIS(LANE_H), .LANE(`LANE_Y4)) u_ball4 (
        .x, .y, .pos(obstacle_pos[4]), .ball_on(ball_on[4]));
    ball_renderer #(.AXIS(LANE_H), .LANE(`LANE_Y5)) u_ball5 (
        .x, .y, .pos(obstacle_pos[5]), .ball_on(ball_on[5]));

    maze_walls u_walls (
        .player_x, .player_y, .can_up, .can_down, .can_left, .can_right
    );

    player_motion u_player (
        .clk, .reset, .frame_tick, .up, .down, .left, .right,
        .can_up, .can_down, .can_left, .can_right,
        .obstacle_pos, .player_x, .player_y
    );

    pixel_mux u_mux (
        .video_on, .x, .y, .player_x, .player_y, .ball_on, .rgb
    );

endmodule

`default_nettype wire

/* source/pixel_mux.sv */
`default_nettype none

`include "maze_defs.svh"

module pixel_mux (
    input  wire logic                              video_on,
    input  wire video_pkg::coord_t                 x,
    input  wire video_pkg::coord_t                 y,
    input  wire video_pkg::coord_t                 player_x,
    input  wire video_pkg::coord_t                 player_y,
    input  wire logic [game_pkg::NUM_OBSTACLES-1:0] ball_on,
    output video_pkg::rgb_t                        rgb
);

    import video_pkg::*;

    coord_t dx;
    coord_t dy;
    logic   player_on;

    assign dx = x - player_x;
    assign dy = y - player_y;
    assign player_on = (x >= player_x) && (dx < `PLAYER_SIZE) &&
                       (y >= player_y) && (dy < `PLAYER_SIZE);

    // obstacles are drawn over the player
    always_comb begin
        if (!video_on)      rgb = `BLACK_RGB;
        else if (|ball_on)  rgb = `BALL_RGB;
        else if (player_on) rgb = `PLAYER_RGB;
        else                rgb = `BACKGROUND_RGB;
    end

endmodule

`default_nettype wire

/* source/player_motion.sv */
`default_nettype none

`include "maze_defs.svh"

module player_motion (
    input  wire logic                                           clk,
    input  wire logic                                           reset,
    input  wire logic                                           frame_tick,
    input  wire logic                                           up,
    input  wire logic                                           down,
    input  wire logic                                           left,
    input  wire logic                                           right,
    input  wire logic                                           can_up,
    input  wire logic                                           can_down,
    input  wire logic                                           can_left,
    input  wire logic                                           can_right,
    input  wire video_pkg::coord_t [game_pkg::NUM_OBSTACLES-1:0] obstacle_pos,
    output video_pkg::coord_t                                   player_x,
    output video_pkg::coord_t                                   player_y
);

    import video_pkg::*;
    import game_pkg::*;

    localparam int NUM_VERTICAL = 4;   // obstacles 0..3 run along y
    localparam coord_t [NUM_OBSTACLES-1:0] LANES = {
        `LANE_Y5, `LANE_Y4, `LANE_X3, `LANE_X2, `LANE_X1, `LANE_X0
    };

    logic [NUM_OBSTACLES-1:0] hit;

    // inclusive box overlap with each obstacle
    for (genvar i = 0; i < NUM_OBSTACLES; i++) begin : g_hit
        coord_t bx;
        coord_t by;
        assign bx = (i < NUM_VERTICAL) ? LANES[i] : obstacle_pos[i];
        assign by = (i < NUM_VERTICAL) ? obstacle_pos[i] : LANES[i];
        assign hit[i] = (bx < player_x + `PLAYER_SIZE) && (player_x < bx + `BALL_SIZE) &&
                        (by < player_y + `PLAYER_SIZE) && (player_y < by + `BALL_SIZE);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            player_x <= `PLAYER_START_X;
            player_y <= `PLAYER_START_Y;
        end else if (frame_tick) begin
            if (|hit) begin
                player_x <= `PLAYER_START_X;   // caught, back to start
                player_y <= `PLAYER_START_Y;
            end else begin
                if (up && can_up)       player_y <= player_y - `PLAYER_STEP;
                if (down && can_down)   player_y <= player_y + `PLAYER_STEP;   // wins over up
                if (left && can_left)   player_x <= player_x - `PLAYER_STEP;
                if (right && can_right) player_x <= player_x + `PLAYER_STEP;
            end
        end
    end

    // player only moves on the frame tick
    a_hold: assert property (@(posedge clk) disable iff (reset)
        !frame_tick |=> $stable({player_x, player_y}));

endmodule

`default_nettype wire

/* source/maze_walls.sv */
`default_nettype none

`include "maze_defs.svh"

module maze_walls (
    input  wire video_pkg::coord_t player_x,
    input  wire video_pkg::coord_t player_y,
    output logic                   can_up,
    output logic                   can_down,
    output logic                   can_left,
    output logic                   can_right
);

    // lower start corridor, left shaft, upper corridor and right shaft
    assign can_up =
        (player_x <= `COR_LEFT && player_y > `COR_LOWER_TOP) ||
        (player_x >= `COR_LEFT && player_x < `COR_RIGHT && player_y > `COR_TOP) ||
        (player_x > `COR_RIGHT && player_y > `COR_LOWER_TOP);

    assign can_down =
        (player_x <= `COR_SHAFT_END && player_y < `COR_LOWER_FLOOR) ||
        (player_x >= `COR_SHAFT_END && player_x < `COR_MID && player_y < `COR_UPPER_FLOOR) ||
        (player_x >= `COR_MID && player_y < `COR_LOWER_FLOOR);

    // no step left of the screen edge at x = 0
    assign can_left =
        (player_y >= `COR_LOWER_TOP && player_y < `COR_MID &&
         player_x != '0 && player_x <= `COR_SHAFT_END) ||
        (player_y >= `COR_TOP && player_y < `COR_LOWER_TOP &&
         player_x > `COR_LEFT && player_x <= `COR_SHAFT_END) ||
        (player_y >= `COR_TOP && player_y < `COR_UPPER_BOT &&
         player_x > `COR_SHAFT_END && player_x < `COR_RIGHT) ||
        (player_y > `COR_UPPER_BOT && player_y < `COR_MID &&
         player_x > `COR_MID && player_x < `COR_RIGHT) ||
        (player_y >= `COR_LOWER_TOP && player_y < `COR_MID && player_x >= `COR_RIGHT);

    assign can_right =
        (player_y >= `COR_LOWER_TOP && player_y < `COR_MID && player_x <= `COR_LEFT) ||
        (player_y > `COR_UPPER_BOT && player_y < `COR_MID &&
         player_x >= `COR_LEFT && player_x < `COR_SHAFT_R) ||
        (player_y >= `COR_TOP && player_y < `COR_UPPER_BOT &&
         player_x >= `COR_LEFT && player_x <= `COR_MID) ||
        (player_y >= `COR_TOP && player_y < `COR_LOWER_TOP &&
         player_x >= `COR_MID && player_x <= `COR_RIGHT) ||
        (player_y >= `COR_LOWER_TOP && player_y < `COR_MID && player_x > `COR_MID);

endmodule

`default_nettype wire

/* source/obstacle_motion.sv */
`default_nettype none

`include "maze_defs.svh"

module obstacle_motion (
    input  wire logic                                           clk,
    input  wire logic                                           reset,
    input  wire video_pkg::coord_t                              x,
    input  wire video_pkg::coord_t                              y,
    output logic                                                frame_tick,
    output video_pkg::coord_t [game_pkg::NUM_OBSTACLES-1:0]     obstacle_pos
);

    import video_pkg::*;
    import game_pkg::*;

    dir_t dir_a;    // obstacles 0 and 2
    dir_t dir_b;    // obstacles 1 and 3
    dir_t dir_4;
    dir_t dir_5;
    logic go_a;
    logic go_b;
    logic go_4;
    logic go_5;

    // true when a mover still has room in its current direction
    function automatic logic has_room(coord_t p, dir_t d, coord_t lo, coord_t hi);
        has_room = (d == DIR_LOW) ? (p > lo) : (p < hi);
    endfunction

    function automatic coord_t stepped(coord_t p, dir_t d);
        stepped = (d == DIR_LOW) ? p - `BALL_STEP : p + `BALL_STEP;
    endfunction

    assign frame_tick = (x == `TICK_X) && (y == `TICK_Y);   // once per frame

    // a pair only moves when both members can
    assign go_a = has_room(obstacle_pos[0], dir_a, `V_MIN, `V_MAX) &&
                  has_room(obstacle_pos[2], dir_a, `V_MIN, `V_MAX);
    assign go_b = has_room(obstacle_pos[1], dir_b, `V_MIN, `V_MAX) &&
                  has_room(obstacle_pos[3], dir_b, `V_MIN, `V_MAX);
    assign go_4 = has_room(obstacle_pos[4], dir_4, `H_MIN, `H_MAX);
    assign go_5 = has_room(obstacle_pos[5], dir_5, `H_MIN, `H_MAX);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            obstacle_pos[0] <= `START_Y0;
            obstacle_pos[1] <= `START_Y1;
            obstacle_pos[2] <= `START_Y2;
            obstacle_pos[3] <= `START_Y3;
            obstacle_pos[4] <= `START_X4;
            obstacle_pos[5] <= `START_X5;
            dir_a <= DIR_LOW;
            dir_b <= DIR_HIGH;
            dir_4 <= DIR_LOW;
            dir_5 <= DIR_HIGH;
        end else if (frame_tick) begin
            if (go_a) begin
                obstacle_pos[0] <= stepped(obstacle_pos[0], dir_a);
                obstacle_pos[2] <= stepped(obstacle_pos[2], dir_a);
            end else begin
                dir_a <= dir_t'(~dir_a);    // bounce, no move this frame
            end
            if (go_b) begin
                obstacle_pos[1] <= stepped(obstacle_pos[1], dir_b);
                obstacle_pos[3] <= stepped(obstacle_pos[3], dir_b);
            end else begin
                dir_b <= dir_t'(~dir_b);
            end
            if (go_4) obstacle_pos[4] <= stepped(obstacle_pos[4], dir_4);
            else      dir_4 <= dir_t'(~dir_4);
            if (go_5) obstacle_pos[5] <= stepped(obstacle_pos[5], dir_5);
            else      dir_5 <= dir_t'(~dir_5);
        end
    end

    // horizontal movers stay inside their limits, give or take one step
    a_h_limits: assert property (@(posedge clk) disable iff (reset)
        obstacle_pos[4] >= `H_MIN - `BALL_STEP && obstacle_pos[4] <= `H_MAX + `BALL_STEP &&
        obstacle_pos[5] >= `H_MIN - `BALL_STEP && obstacle_pos[5] <= `H_MAX + `BALL_STEP);

endmodule

`default_nettype wire

/* source/ball_renderer.sv */
`default_nettype none

`include "maze_defs.svh"

module ball_renderer #(
    parameter game_pkg::lane_axis_t AXIS = game_pkg::LANE_V,
    parameter video_pkg::coord_t    LANE = '0
) (
    input  wire video_pkg::coord_t x,
    input  wire video_pkg::coord_t y,
    input  wire video_pkg::coord_t pos,
    output logic                   ball_on
);

    import video_pkg::*;
    import game_pkg::*;

    coord_t     box_left;
    coord_t     box_top;
    coord_t     dx;
    coord_t     dy;
    logic       in_box;
    logic [7:0] row_bits;

    // lane fixes one edge, pos the other
    assign box_left = (AXIS == LANE_V) ? LANE : pos;
    assign box_top  = (AXIS == LANE_V) ? pos : LANE;

    assign dx = x - box_left;
    assign dy = y - box_top;

    assign in_box = (x >= box_left) && (dx < `BALL_SIZE) &&
                    (y >= box_top) && (dy < `BALL_SIZE);

    ball_rom u_rom (
        .row  (dy[2:0]),
        .bits (row_bits)
    );

    assign ball_on = in_box & row_bits[dx[2:0]];   // bit 0 is the left column

endmodule

`default_nettype wire

/* source/ball_rom.sv */
`default_nettype none

module ball_rom (
    input  wire logic [2:0] row,
    output logic      [7:0] bits
);

    // round ball, corners left clear
    always_comb begin
        case (row)
            3'd0: bits = 8'b0011_1100;
            3'd1: bits = 8'b0111_1110;
            3'd2: bits = 8'b1111_1111;
            3'd3: bits = 8'b1111_1111;
            3'd4: bits = 8'b1111_1111;
            3'd5: bits = 8'b1111_1111;
            3'd6: bits = 8'b0111_1110;
            3'd7: bits = 8'b0011_1100;
        endcase
    end

endmodule

`default_nettype wire

/* source/game_pkg.sv */
`default_nettype none

package game_pkg;

    // sense of motion along an axis
    typedef enum logic {
        DIR_LOW  = 1'b0,    // toward smaller coordinates
        DIR_HIGH = 1'b1
    } dir_t;

    typedef enum logic {
        LANE_H = 1'b0,      // moves along x
        LANE_V = 1'b1       // moves along y
    } lane_axis_t;

    localparam int NUM_OBSTACLES = 6;

endpackage

`default_nettype wire

/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

    // one screen axis, 0..639 or 0..524 with blanking
    typedef logic [9:0] coord_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] rgb_t;

endpackage

`default_nettype wire

/* source/maze_defs.svh */
`ifndef MAZE_DEFS_SVH
`define MAZE_DEFS_SVH

// object sizes and speeds, in pixels
`define BALL_SIZE       10'd8
`define PLAYER_SIZE     10'd12
`define BALL_STEP       10'd3
`define PLAYER_STEP     10'd1

// first pixel of vertical retrace
`define TICK_X          10'd0
`define TICK_Y          10'd481

// fixed lane of each obstacle
`define LANE_X0         10'd165
`define LANE_X1         10'd190
`define LANE_X2         10'd394
`define LANE_X3         10'd426
`define LANE_Y4         10'd74
`define LANE_Y5         10'd106

// bounce limits
`define H_MIN           10'd160
`define H_MAX           10'd436
`define V_MIN           10'd65
`define V_MAX           10'd372

// start positions
`define START_Y0        10'd65
`define START_Y1        10'd64
`define START_Y2        10'd64
`define START_Y3        10'd372
`define START_X4        10'd160
`define START_X5        10'd436
`define PLAYER_START_X  10'd16
`define PLAYER_START_Y  10'd360

`define BALL_RGB        12'hFFF
`define PLAYER_RGB      12'hAAA
`define BACKGROUND_RGB  12'h0E0
`define BLACK_RGB       12'h000

// corridor edges of the maze
`define COR_TOP         10'd64
`define COR_UPPER_FLOOR 10'd116
`define COR_UPPER_BOT   10'd128
`define COR_LEFT        10'd160
`define COR_SHAFT_R     10'd212
`define COR_SHAFT_END   10'd224
`define COR_LOWER_TOP   10'd320
`define COR_LOWER_FLOOR 10'd372
`define COR_MID         10'd384
`define COR_RIGHT       10'd448

`endif
